/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dual_fetch
FILELIST  ?= dual_fetch.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= *** TEST PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# passes only when the pass line shows up in the output
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dual_fetch.f */
src/fetch_pkg.sv
src/pc_gen.sv
src/fetch_unit.sv
src/instr_buffer.sv
src/dual_fetch_top.sv
sim/dual_fetch_assert.sv
sim/tb_dual_fetch.sv

/* sim/dual_fetch_assert.sv */
`timescale 1ns/1ps

module dual_fetch_assert #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = fetch_pkg::DEFAULT_RESET_PC
) (
    input  logic                              clk,
    input  logic                              i_reset,
    input  logic                              i_req_valid,
    input  logic [fetch_pkg::XLEN-1:0]        i_req_addr,
    input  logic                              i_req_ready,
    input  logic                              i_redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]        i_redirect_target,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] i_dec_valid,
    input  logic [fetch_pkg::XLEN-1:0]        i_dec_pc0,
    input  logic [fetch_pkg::XLEN-1:0]        i_dec_ir0,
    input  logic [fetch_pkg::XLEN-1:0]        i_dec_pc1,
    input  logic [fetch_pkg::XLEN-1:0]        i_dec_ir1,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] i_dec_ready
);

    localparam int               XLEN     = fetch_pkg::XLEN;
    localparam logic [XLEN-1:0] INSN_KEY = 32'h5a5a_0000;   // word at a holds a ^ key

    logic            reset_q;
    logic            hold_pending;     // request stalled on ready last cycle
    logic [XLEN-1:0] prev_addr;
    logic [XLEN-1:0] exp_req_addr;
    logic [XLEN-1:0] exp_take_pc;      // next pc decode should take
    logic            take0;
    logic            take1;

    // first failure kept for the testbench
    int              fail_count = 0;
    string           fail_name;
    logic [XLEN-1:0] fail_got;
    logic [XLEN-1:0] fail_exp;
    time             fail_time;

    // one word at the end of a 16-byte line and a pair anywhere else
    function automatic logic [XLEN-1:0] after_fetch(input logic [XLEN-1:0] a);
        return (a[3:2] == 2'b11) ? a + 32'd4 : a + 32'd8;
    endfunction

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] expected);
        if (fail_count == 0) begin
            fail_name = name;
            fail_got  = got;
            fail_exp  = expected;
            fail_time = $time;
        end
        fail_count = fail_count + 1;
        $error("%s got %h expected %h", name, got, expected);
    endtask

    assign take0 = i_dec_valid[0] && i_dec_ready[0];
    assign take1 = take0 && i_dec_valid[1] && i_dec_ready[1];

    always_ff @(posedge clk) begin
        reset_q   <= i_reset;
        prev_addr <= i_req_addr;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            hold_pending <= 1'b0;
            exp_req_addr <= RESET_PC;
            exp_take_pc  <= RESET_PC;
        end else begin
            hold_pending <= i_req_valid && !i_req_ready;
            if (i_redirect_valid) begin
                exp_req_addr <= i_redirect_target;
                exp_take_pc  <= i_redirect_target;
            end else begin
                if (i_req_valid && i_req_ready) begin
                    exp_req_addr <= after_fetch(i_req_addr);
                end
                if (take1) begin
                    exp_take_pc <= i_dec_pc1 + 32'd4;
                end else if (take0) begin
                    exp_take_pc <= i_dec_pc0 + 32'd4;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory request side

    reset_quiet: assert property (@(posedge clk)
        reset_q |-> !i_req_valid && (i_dec_valid == '0))
        else report_mismatch("o_imem_req_valid/o_dec_valid",
                             {29'd0, i_req_valid, i_dec_valid}, '0);

    req_addr_order: assert property (@(posedge clk) disable iff (i_reset)
        i_req_valid && i_req_ready |-> i_req_addr == exp_req_addr)
        else report_mismatch("o_imem_req_addr", i_req_addr, exp_req_addr);

    req_hold_valid: assert property (@(posedge clk) disable iff (i_reset)
        hold_pending && !i_redirect_valid |-> i_req_valid)
        else report_mismatch("o_imem_req_valid", {31'd0, i_req_valid}, 32'd1);

    req_hold_addr: assert property (@(posedge clk) disable iff (i_reset)
        hold_pending && !i_redirect_valid |-> i_req_addr == prev_addr)
        else report_mismatch("o_imem_req_addr", i_req_addr, prev_addr);

    ////////////////////////////////////////////////////////////////////////////
    // decode side

    lane0_word: assert property (@(posedge clk) disable iff (i_reset)
        i_dec_valid[0] |-> i_dec_ir0 == (i_dec_pc0 ^ INSN_KEY))
        else report_mismatch("o_dec_ir0", i_dec_ir0, i_dec_pc0 ^ INSN_KEY);

    lane1_word: assert property (@(posedge clk) disable iff (i_reset)
        i_dec_valid[1] |-> i_dec_ir1 == (i_dec_pc1 ^ INSN_KEY))
        else report_mismatch("o_dec_ir1", i_dec_ir1, i_dec_pc1 ^ INSN_KEY);

    lane1_pc: assert property (@(posedge clk) disable iff (i_reset)
        i_dec_valid[1] |-> i_dec_pc1 == i_dec_pc0 + 32'd4)
        else report_mismatch("o_dec_pc1", i_dec_pc1, i_dec_pc0 + 32'd4);

    take_stream: assert property (@(posedge clk) disable iff (i_reset)
        take0 |-> i_dec_pc0 == exp_take_pc)
        else report_mismatch("o_dec_pc0", i_dec_pc0, exp_take_pc);

endmodule

bind dual_fetch_top dual_fetch_assert #(
    .RESET_PC (RESET_PC)
) rules_i (
    .clk               (clk),
    .i_reset           (i_reset),
    .i_req_valid       (o_imem_req_valid),
    .i_req_addr        (o_imem_req_addr),
    .i_req_ready       (i_imem_req_ready),
    .i_redirect_valid  (i_redirect_valid),
    .i_redirect_target (i_redirect_target),
    .i_dec_valid       (o_dec_valid),
    .i_dec_pc0         (o_dec_pc0),
    .i_dec_ir0         (o_dec_ir0),
    .i_dec_pc1         (o_dec_pc1),
    .i_dec_ir1         (o_dec_ir1),
    .i_dec_ready       (i_dec_ready)
);

/* sim/tb_dual_fetch.sv */
`timescale 1ns/1ps

module tb_dual_fetch;

    localparam int              XLEN           = fetch_pkg::XLEN;
    localparam logic [XLEN-1:0] RESET_PC       = fetch_pkg::DEFAULT_RESET_PC;
    localparam logic [XLEN-1:0] INSN_KEY       = 32'h5a5a_0000;
    localparam int              CLK_PERIOD     = 100;
    localparam int              DRIVE_DELAY    = 1;
    localparam int              RUN_CYCLES     = 2000;
    localparam int              TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 2;
    localparam int              REDIRECT_ODDS  = 40;    // one redirect per 40 cycles on average

    logic              clk = 1'b0;
    logic              i_reset;
    logic              o_imem_req_valid;
    logic [XLEN-1:0]   o_imem_req_addr;
    logic              i_imem_req_ready;
    logic              i_imem_resp_valid;
    logic [2*XLEN-1:0] i_imem_resp_data;
    logic              i_redirect_valid;
    logic [XLEN-1:0]   i_redirect_target;
    logic [1:0]        o_dec_valid;
    logic [XLEN-1:0]   o_dec_pc0;
    logic [XLEN-1:0]   o_dec_ir0;
    logic [XLEN-1:0]   o_dec_pc1;
    logic [XLEN-1:0]   o_dec_ir1;
    logic [1:0]        i_dec_ready;

    // accepted request addresses and the cycle each response is due
    logic [XLEN-1:0] pend_addr [$];
    int              pend_due  [$];
    int              last_due       = 0;
    int              cycle_count    = 0;
    int              taken_total    = 0;
    int              redirect_total = 0;

    dual_fetch_top #(
        .RESET_PC        (RESET_PC),
        .MAX_OUTSTANDING (2),
        .BUF_DEPTH       (8)
    ) dut_i (
        .clk               (clk),
        .i_reset           (i_reset),
        .o_imem_req_valid  (o_imem_req_valid),
        .o_imem_req_addr   (o_imem_req_addr),
        .i_imem_req_ready  (i_imem_req_ready),
        .i_imem_resp_valid (i_imem_resp_valid),
        .i_imem_resp_data  (i_imem_resp_data),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_target (i_redirect_target),
        .o_dec_valid       (o_dec_valid),
        .o_dec_pc0         (o_dec_pc0),
        .o_dec_ir0         (o_dec_ir0),
        .o_dec_pc1         (o_dec_pc1),
        .o_dec_ir1         (o_dec_ir1),
        .i_dec_ready       (i_dec_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] addr);
        return addr ^ INSN_KEY;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // per-cycle drivers

    task automatic drive_memory();
        logic [XLEN-1:0] addr;
        if (pend_addr.size() != 0 && pend_due[0] <= cycle_count) begin
            addr = pend_addr.pop_front();
            void'(pend_due.pop_front());
            i_imem_resp_valid = 1'b1;
            i_imem_resp_data  = {word_at(addr + 32'd4), word_at(addr)};   // request word low
        end else begin
            i_imem_resp_valid = 1'b0;
            i_imem_resp_data  = '0;
        end
        i_imem_req_ready = ($urandom_range(99) < 70);
    endtask

    task automatic drive_redirect();
        logic [XLEN-1:0] target;
        if ($urandom_range(REDIRECT_ODDS - 1) == 0) begin
            target = RESET_PC + (XLEN'($urandom_range(1023)) << 2);
            if ($urandom_range(3) == 0) begin
                target[3:2] = 2'b11;    // line end, single-lane fetch
            end
            i_redirect_valid  = 1'b1;
            i_redirect_target = target;
            redirect_total++;
        end else begin
            i_redirect_valid = 1'b0;
        end
    endtask

    task automatic drive_decode();
        int odds;
        // slow stretches let the buffer fill and push back on fetch
        odds = ((cycle_count % 256) >= 192) ? 15 : 70;
        i_dec_ready[0] = ($urandom_range(99) < odds);
        i_dec_ready[1] = ($urandom_range(99) < odds);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sampling, timeout and the main sequence

    always @(negedge clk) begin : sample_side
        int lat;
        if (!i_reset && o_imem_req_valid && i_imem_req_ready) begin
            lat = 1 + $urandom_range(3);
            last_due = (cycle_count + lat > last_due) ? cycle_count + lat : last_due + 1;
            pend_addr.push_back(o_imem_req_addr);
            pend_due.push_back(last_due);
        end
        if (!i_reset && o_dec_valid[0] && i_dec_ready[0]) begin
            taken_total += (o_dec_valid[1] && i_dec_ready[1]) ? 2 : 1;
        end
        if (dut_i.rules_i.fail_count != 0) begin
            $display("ERROR at %0t: %s got %h expected %h", dut_i.rules_i.fail_time,
                     dut_i.rules_i.fail_name, dut_i.rules_i.fail_got,
                     dut_i.rules_i.fail_exp);
            fail_run();
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(57));
        i_reset           = 1'b1;
        i_imem_req_ready  = 1'b0;
        i_imem_resp_valid = 1'b0;
        i_imem_resp_data  = '0;
        i_redirect_valid  = 1'b0;
        i_redirect_target = '0;
        i_dec_ready       = 2'b00;

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;

        repeat (RUN_CYCLES) begin
            drive_memory();
            drive_redirect();
            drive_decode();
            @(posedge clk);
            #DRIVE_DELAY;
        end

        if (dut_i.rules_i.fail_count == 0 && taken_total > 0 && redirect_total > 0) begin
            $display("%0d instructions taken, %0d redirects", taken_total, redirect_total);
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("run ended with a failed check or without decode traffic");
            fail_run();
        end
    end

endmodule

/* src/dual_fetch_top.sv */
`timescale 1ns/1ps

module dual_fetch_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC        = fetch_pkg::DEFAULT_RESET_PC,
    parameter int                         MAX_OUTSTANDING = 2,
    parameter int                         BUF_DEPTH       = 8
) (
    input  logic                              clk,
    input  logic                              i_reset,
    // instruction memory
    output logic                              o_imem_req_valid,
    output logic [fetch_pkg::XLEN-1:0]        o_imem_req_addr,
    input  logic                              i_imem_req_ready,
    input  logic                              i_imem_resp_valid,
    input  logic [fetch_pkg::PAIR_W-1:0]      i_imem_resp_data,
    // branch outcome from execute
    input  logic                              i_redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]        i_redirect_target,
    // decode
    output logic [fetch_pkg::FETCH_WIDTH-1:0] o_dec_valid,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_pc0,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_ir0,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_pc1,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_ir1,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] i_dec_ready
);

    localparam int FREE_W = $clog2(BUF_DEPTH + 1);

    logic [fetch_pkg::XLEN-1:0]        pc_if;
    logic                              advance;
    logic [fetch_pkg::FETCH_WIDTH-1:0] push_valid;
    logic [fetch_pkg::XLEN-1:0]        push_pc;
    logic [fetch_pkg::XLEN-1:0]        push_ir0;
    logic [fetch_pkg::XLEN-1:0]        push_ir1;
    logic [FREE_W-1:0]                 free_slots;    // credit back to fetch

    ////////////////////////////////////////////////////////////////////////////
    // pc -> fetch -> buffer

    pc_gen #(
        .RESET_PC (RESET_PC)
    ) pc_gen_inst (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_advance         (advance),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_target (i_redirect_target),
        .o_pc              (pc_if)
    );

    fetch_unit #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .BUF_DEPTH       (BUF_DEPTH)
    ) fetch_unit_inst (
        .clk               (clk),
        .i_reset           (i_reset),
        .i_pc              (pc_if),
        .i_redirect_valid  (i_redirect_valid),
        .i_free_slots      (free_slots),
        .i_imem_req_ready  (i_imem_req_ready),
        .i_imem_resp_valid (i_imem_resp_valid),
        .i_imem_resp_data  (i_imem_resp_data),
        .o_imem_req_valid  (o_imem_req_valid),
        .o_imem_req_addr   (o_imem_req_addr),
        .o_advance         (advance),
        .o_push_valid      (push_valid),
        .o_push_pc         (push_pc),
        .o_push_ir0        (push_ir0),
        .o_push_ir1        (push_ir1)
    );

    instr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) instr_buffer_inst (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_flush      (i_redirect_valid),   // mispredict empties the buffer
        .i_push_valid (push_valid),
        .i_push_pc    (push_pc),
        .i_push_ir0   (push_ir0),
        .i_push_ir1   (push_ir1),
        .i_dec_ready  (i_dec_ready),
        .o_dec_valid  (o_dec_valid),
        .o_dec_pc0    (o_dec_pc0),
        .o_dec_ir0    (o_dec_ir0),
        .o_dec_pc1    (o_dec_pc1),
        .o_dec_ir1    (o_dec_ir1),
        .o_free_slots (free_slots)
    );

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

    // datapath widths
    parameter int XLEN        = 32;
    parameter int FETCH_WIDTH = 2;     // instructions per fetch / per decode handoff
    parameter int INSN_BYTES  = 4;
    parameter int LINE_BYTES  = 16;    // a fetch never crosses a line

    // memory response carries one pair, request word in the low half
    parameter int PAIR_W = FETCH_WIDTH * XLEN;

    parameter logic [XLEN-1:0] DEFAULT_RESET_PC = 32'h1c00_0000;

    // offset fields inside a line
    parameter int INSN_OFS_W = $clog2(INSN_BYTES);
    parameter int LINE_OFS_W = $clog2(LINE_BYTES);

    // sequential step sizes
    parameter logic [XLEN-1:0] INSN_STEP = XLEN'(INSN_BYTES);
    parameter logic [XLEN-1:0] PAIR_STEP = XLEN'(FETCH_WIDTH * INSN_BYTES);

    // pc sits in the last word of its line, so only one instruction fits
    function automatic logic last_in_line(input logic [XLEN-1:0] pc);
        return &pc[LINE_OFS_W-1:INSN_OFS_W];
    endfunction

    // sequential prediction, +4 at the line end, +8 otherwise
    function automatic logic [XLEN-1:0] next_seq_pc(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] step;
        step = last_in_line(pc) ? INSN_STEP : PAIR_STEP;
        return pc + step;
    endfunction

endpackage

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter int MAX_OUTSTANDING = 2,
    parameter int BUF_DEPTH       = 8
) (
    input  logic                              clk,
    input  logic                              i_reset,
    input  logic [fetch_pkg::XLEN-1:0]        i_pc,
    input  logic                              i_redirect_valid,
    input  logic [$clog2(BUF_DEPTH+1)-1:0]    i_free_slots,
    input  logic                              i_imem_req_ready,
    input  logic                              i_imem_resp_valid,
    input  logic [fetch_pkg::PAIR_W-1:0]      i_imem_resp_data,
    output logic                              o_imem_req_valid,
    output logic [fetch_pkg::XLEN-1:0]        o_imem_req_addr,
    output logic                              o_advance,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] o_push_valid,
    output logic [fetch_pkg::XLEN-1:0]        o_push_pc,
    output logic [fetch_pkg::XLEN-1:0]        o_push_ir0,
    output logic [fetch_pkg::XLEN-1:0]        o_push_ir1
);

    localparam int FREE_W = $clog2(BUF_DEPTH + 1);
    localparam int CNT_W  = $clog2(MAX_OUTSTANDING + 1);
    localparam int PTR_W  = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int NEED_W = (CNT_W + 2 > FREE_W) ? CNT_W + 2 : FREE_W;

    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(MAX_OUTSTANDING - 1);
    localparam logic [CNT_W-1:0] MAX_CNT  = CNT_W'(MAX_OUTSTANDING);

    // in-flight queue, oldest request at rd_ptr
    logic [fetch_pkg::XLEN-1:0] q_pc [MAX_OUTSTANDING];
    logic [MAX_OUTSTANDING-1:0] q_stale;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           inflight;

    logic              started;     // low for one cycle after reset
    logic              req_fire;
    logic              resp_pop;
    logic              head_last;
    logic [NEED_W-1:0] need_slots;
    logic [NEED_W-1:0] have_slots;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // request side

    // every in-flight pair plus this one must fit in the buffer
    assign need_slots = (NEED_W'(inflight) + NEED_W'(1)) << 1;
    assign have_slots = NEED_W'(i_free_slots);

    assign o_imem_req_valid = started && !i_redirect_valid
                              && (inflight < MAX_CNT)
                              && (have_slots >= need_slots);
    assign o_imem_req_addr  = i_pc;
    assign req_fire         = o_imem_req_valid && i_imem_req_ready;
    assign o_advance        = req_fire;

    ////////////////////////////////////////////////////////////////////////////
    // response side

    assign resp_pop  = i_imem_resp_valid && (inflight != '0);
    assign head_last = fetch_pkg::last_in_line(q_pc[rd_ptr]);

    // stale responses still pop the queue but push nothing
    assign o_push_valid = (resp_pop && !q_stale[rd_ptr]) ? (head_last ? 2'b01 : 2'b11)
                                                         : 2'b00;
    assign o_push_pc    = q_pc[rd_ptr];
    assign o_push_ir0   = i_imem_resp_data[fetch_pkg::XLEN-1:0];
    assign o_push_ir1   = i_imem_resp_data[fetch_pkg::PAIR_W-1:fetch_pkg::XLEN];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            started  <= 1'b0;
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            inflight <= '0;
            q_stale  <= '0;
        end else begin
            started <= 1'b1;
            if (i_redirect_valid) begin
                q_stale <= '1;   // everything already asked for is wrong path
            end
            if (req_fire) begin
                q_stale[wr_ptr] <= 1'b0;
                wr_ptr          <= next_ptr(wr_ptr);
            end
            if (resp_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({req_fire, resp_pop})
                2'b10:   inflight <= inflight + CNT_W'(1);
                2'b01:   inflight <= inflight - CNT_W'(1);
                default: inflight <= inflight;
            endcase
        end
    end

    // request pc kept for the response
    always_ff @(posedge clk) begin
        if (req_fire) begin
            q_pc[wr_ptr] <= i_pc;
        end
    end

endmodule

/* src/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer #(
    parameter int BUF_DEPTH = 8      // power of two
) (
    input  logic                              clk,
    input  logic                              i_reset,
    input  logic                              i_flush,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] i_push_valid,
    input  logic [fetch_pkg::XLEN-1:0]        i_push_pc,
    input  logic [fetch_pkg::XLEN-1:0]        i_push_ir0,
    input  logic [fetch_pkg::XLEN-1:0]        i_push_ir1,
    input  logic [fetch_pkg::FETCH_WIDTH-1:0] i_dec_ready,
    output logic [fetch_pkg::FETCH_WIDTH-1:0] o_dec_valid,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_pc0,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_ir0,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_pc1,
    output logic [fetch_pkg::XLEN-1:0]        o_dec_ir1,
    output logic [$clog2(BUF_DEPTH+1)-1:0]    o_free_slots
);

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(BUF_DEPTH);

    // entry storage
    logic [fetch_pkg::XLEN-1:0] pc_mem [BUF_DEPTH];
    logic [fetch_pkg::XLEN-1:0] ir_mem [BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr_nx1;
    logic [PTR_W-1:0] wr_ptr_nx1;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_push;
    logic [CNT_W-1:0] n_pop;
    logic             take0;
    logic             take1;

    assign rd_ptr_nx1 = rd_ptr + PTR_W'(1);
    assign wr_ptr_nx1 = wr_ptr + PTR_W'(1);

    ////////////////////////////////////////////////////////////////////////////
    // decode side

    // oldest entry in lane 0, lane 1 only with lane 0
    assign o_dec_valid[0] = (count != '0);
    assign o_dec_valid[1] = (count > CNT_W'(1));

    assign o_dec_pc0 = pc_mem[rd_ptr];
    assign o_dec_ir0 = ir_mem[rd_ptr];
    assign o_dec_pc1 = pc_mem[rd_ptr_nx1];
    assign o_dec_ir1 = ir_mem[rd_ptr_nx1];

    // lane 1 retires only behind lane 0
    assign take0 = o_dec_valid[0] & i_dec_ready[0];
    assign take1 = take0 & o_dec_valid[1] & i_dec_ready[1];
    assign n_pop = CNT_W'(take0) + CNT_W'(take1);

    ////////////////////////////////////////////////////////////////////////////
    // fetch side

    assign n_push       = CNT_W'(i_push_valid[0]) + CNT_W'(i_push_valid[1]);
    assign o_free_slots = DEPTH_C - count;

    // payload writes, lane 1 pc derived here
    always_ff @(posedge clk) begin
        if (!i_flush) begin
            if (i_push_valid[0]) begin
                pc_mem[wr_ptr] <= i_push_pc;
                ir_mem[wr_ptr] <= i_push_ir0;
            end
            if (i_push_valid[1]) begin
                pc_mem[wr_ptr_nx1] <= i_push_pc + fetch_pkg::INSN_STEP;
                ir_mem[wr_ptr_nx1] <= i_push_ir1;
            end
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;     // flush drops same-cycle push too
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(n_pop);
            wr_ptr <= wr_ptr + PTR_W'(n_push);
            count  <= count + n_push - n_pop;
        end
    end

endmodule

/* src/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = fetch_pkg::DEFAULT_RESET_PC
) (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_advance,          // request accepted this cycle
    input  logic                       i_redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0] i_redirect_target,
    output logic [fetch_pkg::XLEN-1:0] o_pc
);

    logic [fetch_pkg::XLEN-1:0] pc_predict;
    logic [fetch_pkg::XLEN-1:0] pc_next;

    // fall-through address for the pair now being fetched
    assign pc_predict = fetch_pkg::next_seq_pc(o_pc);

    // redirect beats advance
    always_comb begin
        if (i_redirect_valid) begin
            pc_next = i_redirect_target;
        end else if (i_advance) begin
            pc_next = pc_predict;
        end else begin
            pc_next = o_pc;     // hold while memory stalls
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc <= RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule
